/* source/mdu_cfg.svh */
`ifndef MDU_CFG_SVH
`define MDU_CFG_SVH

// ----------------------------------------------------------------------
// MDU build options
// ----------------------------------------------------------------------

// Operand and result width of the core
// Products are twice this wide and the divider takes one cycle per bit
`define MDU_XLEN 32

// Chip-select value that routes an instruction to the MDU
`define MDU_CS_CODE 2'b01

// Multiplier bits consumed per cycle
// Legal values are 1, 2 or 4 and the value must divide MDU_XLEN
// Multiply latency is MDU_XLEN / MDU_MUL_BITS + 1 cycles
`define MDU_MUL_BITS 1

`endif

/* source/mdu_pkg.sv */
`default_nettype none

`include "mdu_cfg.svh"

package mdu_pkg;

    // ------------------------------------------------------------------
    // M-extension funct3 field
    // ------------------------------------------------------------------
    // Bit 2 splits multiply from divide
    typedef enum logic [2:0] {
        MUL    = 3'b000,
        MULH   = 3'b001,
        MULHSU = 3'b010,
        MULHU  = 3'b011,
        DIV    = 3'b100,
        DIVU   = 3'b101,
        REM    = 3'b110,
        REMU   = 3'b111
    } muldiv_funct3_t;

    // Shared FSM encoding of the iterative units
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        BUSY = 2'd1,
        DONE = 2'd2
    } unit_state_t;

    // Request from the core, held steady while stalled
    // a is rs1 and b is rs2
    typedef struct packed {
        muldiv_funct3_t           op;
        logic [`MDU_XLEN-1:0]     a;
        logic [`MDU_XLEN-1:0]     b;
    } mdu_req_t;

endpackage

`default_nettype wire

/* source/multiplier_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mdu_cfg.svh"

module multiplier_top (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        start_i,
    input  mdu_pkg::mdu_req_t           req_i,
    output logic [2*`MDU_XLEN-1:0]      product_o,
    output logic                        done_o
);

    localparam int XLEN  = `MDU_XLEN;
    localparam int PW    = 2 * XLEN;
    localparam int BITS  = `MDU_MUL_BITS;
    localparam int STEPS = XLEN / BITS;
    localparam int CW    = $clog2(STEPS + 1);

    mdu_pkg::unit_state_t state_q;
    logic [CW-1:0]        cnt_q;
    logic                 accept;
    logic                 last_step;
    logic                 a_signed;
    logic                 b_signed;
    logic                 a_neg;
    logic                 b_neg;
    logic [XLEN-1:0]      a_mag;
    logic [XLEN-1:0]      b_mag;
    logic [PW-1:0]        mcand_q;
    logic [XLEN-1:0]      mplier_q;
    logic [PW-1:0]        acc_q;
    logic [PW-1:0]        partial;
    logic [PW-1:0]        acc_sum;
    logic [PW-1:0]        product_q;
    logic                 neg_q;

    // Radix has to split the word evenly
    if ((XLEN % BITS) != 0) begin : g_radix_check
        $error("MDU_MUL_BITS must divide MDU_XLEN");
    end

    // ------------------------------------------------------------------
    // Operand signedness
    // ------------------------------------------------------------------
    always_comb begin
        // MULH is signed x signed, MULHSU signed x unsigned
        a_signed = (req_i.op == mdu_pkg::MULH) || (req_i.op == mdu_pkg::MULHSU);
        b_signed = (req_i.op == mdu_pkg::MULH);
        a_neg    = a_signed & req_i.a[XLEN-1];
        b_neg    = b_signed & req_i.b[XLEN-1];
        // Most negative value maps to its own unsigned magnitude
        a_mag    = a_neg ? -req_i.a : req_i.a;
        b_mag    = b_neg ? -req_i.b : req_i.b;
    end

    // Start only lands when no operation is in flight
    assign accept = start_i && (state_q != mdu_pkg::BUSY);

    // Shift-add step, one multiplier digit per cycle
    always_comb begin
        partial   = mcand_q * PW'(mplier_q[BITS-1:0]);
        acc_sum   = acc_q + partial;
        last_step = (cnt_q == CW'(STEPS - 1));
    end

    // ------------------------------------------------------------------
    // Control FSM
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= mdu_pkg::IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                mdu_pkg::BUSY: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (last_step) begin
                        state_q <= mdu_pkg::DONE;
                    end
                end
                default: begin
                    // DONE lasts one cycle, then back to idle unless restarted
                    if (accept) begin
                        state_q <= mdu_pkg::BUSY;
                        cnt_q   <= '0;
                    end else begin
                        state_q <= mdu_pkg::IDLE;
                    end
                end
            endcase
        end
    end

    // Datapath
    always_ff @(posedge clk_i) begin
        if (accept) begin
            mcand_q  <= PW'(a_mag);
            mplier_q <= b_mag;
            acc_q    <= '0;
            neg_q    <= a_neg ^ b_neg;
        end else if (state_q == mdu_pkg::BUSY) begin
            mcand_q  <= mcand_q << BITS;
            mplier_q <= mplier_q >> BITS;
            acc_q    <= acc_sum;
            // Sign fix on the final sum
            if (last_step) begin
                product_q <= neg_q ? -acc_sum : acc_sum;
            end
        end
    end

    assign product_o = product_q;
    assign done_o    = (state_q == mdu_pkg::DONE);

    a_no_start_busy: assert property (@(posedge clk_i) disable iff (rst_i)
        (state_q == mdu_pkg::BUSY) |-> !start_i)
        else $error("multiplier start while busy");

    a_done_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        done_o |=> !done_o)
        else $error("multiplier done held for two cycles");

endmodule

`default_nettype wire

/* source/divider_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mdu_cfg.svh"

module divider_top (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        start_i,
    input  mdu_pkg::mdu_req_t           req_i,
    output logic [`MDU_XLEN-1:0]        quotient_o,
    output logic [`MDU_XLEN-1:0]        remainder_o,
    output logic                        done_o
);

    localparam int XLEN = `MDU_XLEN;
    localparam int CW   = $clog2(XLEN + 1);

    mdu_pkg::unit_state_t state_q;
    logic [CW-1:0]        cnt_q;
    logic                 accept;
    logic                 last_step;
    logic                 is_signed;
    logic                 a_neg;
    logic                 b_neg;
    logic                 div_zero;
    logic                 overflow;
    logic [XLEN-1:0]      a_mag;
    logic [XLEN-1:0]      b_mag;
    logic [XLEN-1:0]      dvsr_q;
    logic [XLEN-1:0]      quo_q;
    logic [XLEN-1:0]      rem_q;
    logic [XLEN:0]        shifted;
    logic [XLEN:0]        diff;
    logic                 fits;
    logic [XLEN-1:0]      rem_next;
    logic [XLEN-1:0]      quo_next;
    logic [XLEN-1:0]      quotient_q;
    logic [XLEN-1:0]      remainder_q;
    logic                 q_neg_q;
    logic                 r_neg_q;

    // ------------------------------------------------------------------
    // Operand decode and special cases
    // ------------------------------------------------------------------
    always_comb begin
        // DIV and REM are signed, DIVU and REMU unsigned
        is_signed = (req_i.op == mdu_pkg::DIV) || (req_i.op == mdu_pkg::REM);
        a_neg     = is_signed & req_i.a[XLEN-1];
        b_neg     = is_signed & req_i.b[XLEN-1];
        a_mag     = a_neg ? -req_i.a : req_i.a;
        b_mag     = b_neg ? -req_i.b : req_i.b;
        div_zero  = (req_i.b == '0);
        // Most negative value over -1 does not fit
        overflow  = is_signed && (req_i.a == {1'b1, {(XLEN-1){1'b0}}})
                    && (req_i.b == '1);
    end

    assign accept = start_i && (state_q != mdu_pkg::BUSY);

    // Restoring step
    always_comb begin
        // Bring down the next dividend bit
        shifted   = {rem_q, quo_q[XLEN-1]};
        diff      = shifted - {1'b0, dvsr_q};
        fits      = (shifted >= {1'b0, dvsr_q});
        rem_next  = fits ? diff[XLEN-1:0] : shifted[XLEN-1:0];
        quo_next  = {quo_q[XLEN-2:0], fits};
        last_step = (cnt_q == CW'(XLEN - 1));
    end

    // ------------------------------------------------------------------
    // Control FSM
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= mdu_pkg::IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                mdu_pkg::BUSY: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (last_step) begin
                        state_q <= mdu_pkg::DONE;
                    end
                end
                default: begin
                    if (accept) begin
                        // Special cases skip the loop
                        state_q <= (div_zero || overflow) ? mdu_pkg::DONE : mdu_pkg::BUSY;
                        cnt_q   <= '0;
                    end else begin
                        state_q <= mdu_pkg::IDLE;
                    end
                end
            endcase
        end
    end

    // Datapath
    always_ff @(posedge clk_i) begin
        if (accept) begin
            dvsr_q  <= b_mag;
            quo_q   <= a_mag;
            rem_q   <= '0;
            // Quotient sign from both operands, remainder follows the dividend
            q_neg_q <= a_neg ^ b_neg;
            r_neg_q <= a_neg;
            if (div_zero) begin
                quotient_q  <= '1;
                remainder_q <= req_i.a;
            end else if (overflow) begin
                quotient_q  <= req_i.a;
                remainder_q <= '0;
            end
        end else if (state_q == mdu_pkg::BUSY) begin
            rem_q <= rem_next;
            quo_q <= quo_next;
            if (last_step) begin
                quotient_q  <= q_neg_q ? -quo_next : quo_next;
                remainder_q <= r_neg_q ? -rem_next : rem_next;
            end
        end
    end

    assign quotient_o  = quotient_q;
    assign remainder_o = remainder_q;
    assign done_o      = (state_q == mdu_pkg::DONE);

    a_no_start_busy: assert property (@(posedge clk_i) disable iff (rst_i)
        (state_q == mdu_pkg::BUSY) |-> !start_i)
        else $error("divider start while busy");

    a_zero_div_ones: assert property (@(posedge clk_i) disable iff (rst_i)
        (accept && (req_i.b == '0)) |=> (done_o && (quotient_o == '1)))
        else $error("divide by zero did not give all-ones quotient");

endmodule

`default_nettype wire

/* source/mdu.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mdu_cfg.svh"

module mdu (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic [1:0]                  chip_select_i,
    input  mdu_pkg::mdu_req_t           req_i,
    output logic [`MDU_XLEN-1:0]        result_o,
    output logic                        mul_stall_o,
    output logic                        div_stall_o
);

    localparam int XLEN = `MDU_XLEN;

    logic                 selected;
    logic                 mul_sel;
    logic                 div_sel;
    logic                 mul_run_q;
    logic                 div_run_q;
    logic                 mul_start;
    logic                 div_start;
    logic [2*XLEN-1:0]    product;
    logic [XLEN-1:0]      quotient;
    logic [XLEN-1:0]      remainder;
    logic                 mul_done;
    logic                 div_done;
    logic [XLEN-1:0]      sel_word;
    logic [XLEN-1:0]      result_q;

    // ------------------------------------------------------------------
    // Opcode decode and start pulses
    // ------------------------------------------------------------------
    assign selected = (chip_select_i == `MDU_CS_CODE);
    // funct3 bit 2 picks the divider
    assign mul_sel  = selected && !req_i.op[2];
    assign div_sel  = selected && req_i.op[2];

    // One start per instruction, blocked while the unit runs
    assign mul_start = mul_sel && !mul_run_q;
    assign div_start = div_sel && !div_run_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mul_run_q <= 1'b0;
            div_run_q <= 1'b0;
            result_q  <= '0;
        end else begin
            if (mul_start) begin
                mul_run_q <= 1'b1;
            end else if (mul_done) begin
                mul_run_q <= 1'b0;
            end
            if (div_start) begin
                div_run_q <= 1'b1;
            end else if (div_done) begin
                div_run_q <= 1'b0;
            end
            // Keep last result for when the MDU is deselected
            if (mul_done || div_done) begin
                result_q <= sel_word;
            end
        end
    end

    // ------------------------------------------------------------------
    // Iterative units
    // ------------------------------------------------------------------
    multiplier_top u_multiplier_top (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .start_i   (mul_start),
        .req_i     (req_i),
        .product_o (product),
        .done_o    (mul_done)
    );

    divider_top u_divider_top (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .start_i     (div_start),
        .req_i       (req_i),
        .quotient_o  (quotient),
        .remainder_o (remainder),
        .done_o      (div_done)
    );

    // Stall until the unit reports done, low in the done cycle itself
    assign mul_stall_o = mul_sel && !mul_done;
    assign div_stall_o = div_sel && !div_done;

    // ------------------------------------------------------------------
    // Result select
    // ------------------------------------------------------------------
    always_comb begin
        case (req_i.op)
            mdu_pkg::MUL:    sel_word = product[XLEN-1:0];
            mdu_pkg::MULH,
            mdu_pkg::MULHSU,
            mdu_pkg::MULHU:  sel_word = product[2*XLEN-1:XLEN];
            mdu_pkg::DIV,
            mdu_pkg::DIVU:   sel_word = quotient;
            mdu_pkg::REM,
            mdu_pkg::REMU:   sel_word = remainder;
            default:         sel_word = '0;
        endcase
    end

    // Fresh word in the done cycle, held word otherwise
    assign result_o = (mul_done || div_done) ? sel_word : result_q;

    a_stall_excl: assert property (@(posedge clk_i) disable iff (rst_i)
        !(mul_stall_o && div_stall_o))
        else $error("multiply and divide stall together");

endmodule

`default_nettype wire

/* tests/mdu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mdu_cfg.svh"

module mdu_tb;

    localparam int XLEN     = `MDU_XLEN;
    localparam int MUL_BITS = `MDU_MUL_BITS;
    localparam int TIMEOUT  = 200;
    localparam logic [XLEN-1:0] MIN_VAL = {1'b1, {(XLEN-1){1'b0}}};

    logic                 clk_i;
    logic                 rst_i;
    logic [1:0]           chip_select_i;
    mdu_pkg::mdu_req_t    req_i;
    logic [XLEN-1:0]      result_o;
    logic                 mul_stall_o;
    logic                 div_stall_o;

    logic [15:0]          lfsr_state;
    int                   check_count;
    int                   error_count;
    int                   test_checks;
    int                   test_errors;
    logic [XLEN-1:0]      last_result;

    mdu DUT (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .chip_select_i (chip_select_i),
        .req_i         (req_i),
        .result_o      (result_o),
        .mul_stall_o   (mul_stall_o),
        .div_stall_o   (div_stall_o)
    );

    // 10 ns clock
    initial clk_i = 1'b0;
    always #5 clk_i = ~clk_i;

    // ------------------------------------------------------------------
    // Random source
    // ------------------------------------------------------------------
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Mostly random words with the usual corners mixed in
    function automatic logic [XLEN-1:0] rand_operand();
        logic [31:0] pick;
        pick = rand_bits(4);
        case (pick[3:0])
            4'd0:    return '0;
            4'd1:    return XLEN'(1);
            4'd2:    return '1;
            4'd3:    return MIN_VAL;
            default: return XLEN'(rand_bits(XLEN));
        endcase
    endfunction

    function automatic mdu_pkg::muldiv_funct3_t rand_op(input logic divide);
        logic [31:0] bits;
        bits = rand_bits(3);
        // Bit 2 forced to pick the unit
        return mdu_pkg::muldiv_funct3_t'({divide, bits[1:0]});
    endfunction

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    function automatic logic [XLEN-1:0] expected_result(
        input mdu_pkg::muldiv_funct3_t op,
        input logic [XLEN-1:0]         a,
        input logic [XLEN-1:0]         b
    );
        logic signed [2*XLEN-1:0] sa;
        logic signed [2*XLEN-1:0] sb;
        logic [2*XLEN-1:0]        ua;
        logic [2*XLEN-1:0]        ub;
        logic [2*XLEN-1:0]        p;
        logic signed [2*XLEN-1:0] q;
        logic [XLEN-1:0]          r;
        sa = {{XLEN{a[XLEN-1]}}, a};
        sb = {{XLEN{b[XLEN-1]}}, b};
        ua = {{XLEN{1'b0}}, a};
        ub = {{XLEN{1'b0}}, b};
        r  = '0;
        case (op)
            mdu_pkg::MUL: begin
                p = ua * ub;
                r = p[XLEN-1:0];
            end
            mdu_pkg::MULH: begin
                p = sa * sb;
                r = p[2*XLEN-1:XLEN];
            end
            // Signed rs1 times unsigned rs2 fits in the double width
            mdu_pkg::MULHSU: begin
                p = sa * ub;
                r = p[2*XLEN-1:XLEN];
            end
            mdu_pkg::MULHU: begin
                p = ua * ub;
                r = p[2*XLEN-1:XLEN];
            end
            mdu_pkg::DIV: begin
                q = sa / sb;
                r = (b == '0) ? '1 : ((a == MIN_VAL && b == '1) ? a : q[XLEN-1:0]);
            end
            mdu_pkg::DIVU: begin
                r = (b == '0) ? '1 : a / b;
            end
            // Remainder keeps the dividend's sign
            mdu_pkg::REM: begin
                q = sa % sb;
                r = (b == '0) ? a : ((a == MIN_VAL && b == '1) ? '0 : q[XLEN-1:0]);
            end
            default: begin
                r = (b == '0) ? a : a % b;
            end
        endcase
        return r;
    endfunction

    // Stall length of one operation without the done cycle
    function automatic int expected_cycles(
        input mdu_pkg::muldiv_funct3_t op,
        input logic [XLEN-1:0]         a,
        input logic [XLEN-1:0]         b
    );
        logic signed_div;
        signed_div = (op == mdu_pkg::DIV) || (op == mdu_pkg::REM);
        if (!op[2]) begin
            return XLEN / MUL_BITS + 1;
        end
        if (b == '0 || (signed_div && a == MIN_VAL && b == '1)) begin
            return 1;
        end
        return XLEN + 1;
    endfunction

    // ------------------------------------------------------------------
    // Checking and reporting
    // ------------------------------------------------------------------
    task automatic check_value(
        input string           name,
        input logic [XLEN-1:0] expected,
        input logic [XLEN-1:0] actual
    );
        check_count++;
        test_checks++;
        if (actual !== expected) begin
            error_count++;
            test_errors++;
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic begin_test();
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d checks, %0d errors", name, test_checks, test_errors);
    endtask

    // Issue one instruction and follow it to its done cycle
    task automatic run_op(
        input mdu_pkg::muldiv_funct3_t op,
        input logic [XLEN-1:0]         a,
        input logic [XLEN-1:0]         b,
        input logic [XLEN-1:0]         expected,
        input int                      exp_cycles
    );
        int    cycles;
        int    waited;
        logic  is_div;
        logic  stall;
        logic  other;
        string other_name;
        is_div     = op[2];
        other_name = is_div ? "mul_stall_o" : "div_stall_o";
        @(posedge clk_i);
        chip_select_i <= `MDU_CS_CODE;
        req_i         <= '{op: op, a: a, b: b};
        cycles = 0;
        waited = 0;
        stall  = 1'b1;
        // Sample mid-cycle away from the drive edge
        while (stall) begin
            @(negedge clk_i);
            stall = is_div ? div_stall_o : mul_stall_o;
            other = is_div ? mul_stall_o : div_stall_o;
            check_value(other_name, '0, XLEN'(other));
            if (stall) begin
                cycles++;
            end
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout: stall for %s did not drop within %0d cycles",
                         op.name(), TIMEOUT);
                $display("TEST RESULT: FAIL");
                $finish;
            end
        end
        // Result is combinational in the done cycle
        check_value("result_o", expected, result_o);
        check_value("stall cycles", XLEN'(exp_cycles), XLEN'(cycles));
        last_result = expected;
    endtask

    task automatic run_random(input logic divide);
        mdu_pkg::muldiv_funct3_t op;
        logic [XLEN-1:0]         a;
        logic [XLEN-1:0]         b;
        op = rand_op(divide);
        a  = rand_operand();
        b  = rand_operand();
        run_op(op, a, b, expected_result(op, a, b), expected_cycles(op, a, b));
    endtask

    task automatic deselect();
        @(posedge clk_i);
        chip_select_i <= 2'b00;
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        logic [XLEN-1:0]   a;
        logic [31:0]       cs_bits;
        logic [31:0]       unit_bits;
        mdu_pkg::mdu_req_t next_req;
        lfsr_state    = 16'd61274;
        check_count   = 0;
        error_count   = 0;
        last_result   = '0;
        rst_i         = 1'b1;
        chip_select_i = 2'b00;
        req_i         = '0;

        // Reset held for 5 cycles
        repeat (5) @(posedge clk_i);
        rst_i <= 1'b0;

        begin_test();
        @(negedge clk_i);
        check_value("mul_stall_o", '0, XLEN'(mul_stall_o));
        check_value("div_stall_o", '0, XLEN'(div_stall_o));
        check_value("result_o", '0, result_o);
        end_test("reset state");

        begin_test();
        for (int i = 0; i < 200; i++) begin
            run_random(1'b0);
            deselect();
        end
        end_test("random multiplies");

        begin_test();
        for (int i = 0; i < 200; i++) begin
            run_random(1'b1);
            deselect();
        end
        end_test("random divides");

        // Zero divisor for every divide opcode and then signed overflow
        begin_test();
        a = rand_operand();
        run_op(mdu_pkg::DIV, a, '0, '1, 1);
        run_op(mdu_pkg::DIVU, a, '0, '1, 1);
        run_op(mdu_pkg::REM, a, '0, a, 1);
        run_op(mdu_pkg::REMU, a, '0, a, 1);
        run_op(mdu_pkg::DIV, MIN_VAL, '1, MIN_VAL, 1);
        run_op(mdu_pkg::REM, MIN_VAL, '1, '0, 1);
        deselect();
        end_test("division corners");

        begin_test();
        run_random(1'b0);
        for (int i = 0; i < 10; i++) begin
            @(posedge clk_i);
            cs_bits = rand_bits(2);
            if (cs_bits[1:0] == `MDU_CS_CODE) begin
                cs_bits[1:0] = ~`MDU_CS_CODE;
            end
            unit_bits = rand_bits(1);
            next_req  = '{op: rand_op(unit_bits[0]), a: rand_operand(), b: rand_operand()};
            chip_select_i <= cs_bits[1:0];
            req_i         <= next_req;
            @(negedge clk_i);
            check_value("result_o", last_result, result_o);
            check_value("mul_stall_o", '0, XLEN'(mul_stall_o));
            check_value("div_stall_o", '0, XLEN'(div_stall_o));
        end
        end_test("result hold");

        // Chip select stays up and each new request follows its done
        begin_test();
        for (int i = 0; i < 20; i++) begin
            run_random(i[0]);
        end
        deselect();
        end_test("back-to-back");

        $display("checks passed %0d, failed %0d", check_count - error_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mdu.f */
+incdir+source
source/mdu_pkg.sv
source/multiplier_top.sv
source/divider_top.sv
source/mdu.sv
tests/mdu_tb.sv
